// ==== source/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'hbfc0_0000

// exception vector, used for every exception redirect
`define FETCH_EXC_ENTRY 32'hbfc0_0380

// program counter width
`define FETCH_ADDR_W 32

`endif

// ==== source/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // master side of the instruction bus, wishbone classic, read only
    typedef struct packed {
        logic        cyc;
        logic        stb;
        // always low, the front end never writes
        logic        we;
        // doubleword aligned byte address
        logic [31:0] adr;
    } ibus_req_t;

    // slave side of the instruction bus
    typedef struct packed {
        logic        ack;
        // lower word holds the instruction at adr, upper word the one at adr+4
        logic [63:0] dat;
    } ibus_resp_t;

endpackage

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package pipe_pkg;

    // fetch request in flight between pc select and the bus
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] pc;
        // either low pc bit set, no bus cycle is made
        logic                     bad_addr;
    } fetch1_t;

    // one instruction slot
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [31:0]              raw_instr;
        // address exception, raw_instr is zero
        logic                     exc;
    } slot_t;

    // slot 0 is the older instruction
    typedef struct packed {
        slot_t [1:0] slot;
    } fetch_pair_t;

    // one cycle pulse from the back end
    typedef struct packed {
        logic                     valid;
        // target ignored, the exception entry is used
        logic                     is_exc;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic en,
    input  wire logic flush,
    input  wire T     d,
    output T          q
);

    // flush wins over a load in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

    // a stalled stage must keep its payload
    hold_when_idle_a: assert property (
        @(posedge clk)
        !reset && !en && !flush |=> $stable(q)
    ) else $error("pipe_reg: q changed while not enabled");

endmodule

`default_nettype wire

// ==== source/pc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module pc_select (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire pipe_pkg::redirect_t redirect,
    input  wire logic                advance,
    output pipe_pkg::fetch1_t        f1_next
);

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic [`FETCH_ADDR_W-1:0] pend_target;
    logic [`FETCH_ADDR_W-1:0] cur_pc;
    logic [`FETCH_ADDR_W-1:0] succ_pc;
    logic [`FETCH_ADDR_W-1:0] redir_target;
    logic                     pend_q;
    logic                     pend_exc_q;
    logic                     take_new;

    // a pending redirect replaces the sequential pc
    assign cur_pc = pend_q ? pend_target : pc_q;

    // upper word of a doubleword only yields one slot
    assign succ_pc = cur_pc[2] ? cur_pc + `FETCH_ADDR_W'd4 : cur_pc + `FETCH_ADDR_W'd8;

    assign redir_target = redirect.is_exc ? `FETCH_EXC_ENTRY : redirect.target;

    // a branch never displaces an exception that is still waiting
    assign take_new = redirect.valid && !(pend_q && pend_exc_q && !redirect.is_exc);

    // a redirect always lands in the pending latch.
    // a request accepted in the same cycle is flushed downstream,
    // so the advance is ignored then
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q       <= `FETCH_RESET_PC;
            pend_q     <= 1'b0;
            pend_exc_q <= 1'b0;
        end else if (redirect.valid) begin
            pend_q <= 1'b1;
            if (take_new) begin
                pend_exc_q <= redirect.is_exc;
            end
        end else if (advance) begin
            pc_q       <= succ_pc;
            pend_q     <= 1'b0;
            pend_exc_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_new) begin
            pend_target <= redir_target;
        end
    end

    always_comb begin
        f1_next.valid    = 1'b1;
        f1_next.pc       = cur_pc;
        f1_next.bad_addr = |cur_pc[1:0];
    end

endmodule

`default_nettype wire

// ==== source/ibus_master.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module ibus_master (
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     start,
    input  wire logic [`FETCH_ADDR_W-1:0] adr_in,
    output logic                          busy,
    output bus_pkg::ibus_req_t            ibus_req,
    input  wire bus_pkg::ibus_resp_t      ibus_resp,
    input  wire logic                     drop,
    output logic                          data_valid,
    output logic [63:0]                   data,
    input  wire logic                     take
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_HOLD
    } state_t;

    state_t      state;
    logic [31:0] adr_q;
    logic [63:0] hold_data;
    logic        drop_q;
    logic        done;
    logic        start_ok;

    // current result is consumed or thrown away this cycle
    assign done = (state == S_WAIT && ibus_resp.ack && (take || drop || drop_q))
               || (state == S_HOLD && (take || drop));

    // a request raised together with a redirect is stale
    assign start_ok = start && !drop;

    assign busy = !(state == S_IDLE || done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            adr_q  <= '0;
            drop_q <= 1'b0;
        end else if (state == S_IDLE || done) begin
            drop_q <= 1'b0;
            if (start_ok) begin
                state <= S_WAIT;
                adr_q <= {adr_in[31:3], 3'b000};
            end else begin
                state <= S_IDLE;
            end
        end else if (state == S_WAIT) begin
            if (ibus_resp.ack) begin
                state <= S_HOLD;
            end else if (drop) begin
                // cycle must still finish, result is discarded
                drop_q <= 1'b1;
            end
        end
    end

    // downstream stalled at ack time
    always_ff @(posedge clk) begin
        if (state == S_WAIT && ibus_resp.ack) begin
            hold_data <= ibus_resp.dat;
        end
    end

    assign data_valid = (state == S_WAIT && ibus_resp.ack && !drop_q && !drop)
                     || (state == S_HOLD && !drop);
    assign data = (state == S_HOLD) ? hold_data : ibus_resp.dat;

    always_comb begin
        ibus_req.cyc = (state == S_WAIT);
        ibus_req.stb = (state == S_WAIT);
        ibus_req.we  = 1'b0;
        ibus_req.adr = adr_q;
    end

    // wishbone classic, strobe and address held until the slave acks
    stb_stable_a: assert property (
        @(posedge clk) disable iff (reset)
        ibus_req.stb && !ibus_resp.ack |=> ibus_req.stb && $stable(ibus_req.adr)
    ) else $error("ibus_master: request changed before ack");

endmodule

`default_nettype wire

// ==== source/fetch_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_align (
    input  wire pipe_pkg::fetch1_t f1,
    input  wire logic              data_valid,
    input  wire logic [63:0]       data,
    output pipe_pkg::fetch_pair_t  pair,
    output logic                   pair_ok
);

    logic [31:0] word_lo;
    logic [31:0] word_hi;
    logic        upper;

    assign word_lo = data[31:0];
    assign word_hi = data[63:32];
    assign upper   = f1.pc[2];

    // bad address needs no bus data
    assign pair_ok = f1.valid && (f1.bad_addr || data_valid);

    always_comb begin
        pair = '0;

        // slot 0, the instruction at pc itself
        pair.slot[0].valid = pair_ok;
        pair.slot[0].pc    = f1.pc;
        pair.slot[0].exc   = f1.bad_addr;
        if (f1.bad_addr) begin
            pair.slot[0].raw_instr = '0;
        end else if (upper) begin
            pair.slot[0].raw_instr = word_hi;
        end else begin
            pair.slot[0].raw_instr = word_lo;
        end

        // slot 1 only when pc starts the doubleword
        if (pair_ok && !f1.bad_addr && !upper) begin
            pair.slot[1].valid     = 1'b1;
            pair.slot[1].pc        = f1.pc + 32'd4;
            pair.slot[1].raw_instr = word_hi;
            pair.slot[1].exc       = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  wire logic                clk,
    input  wire logic                reset,
    output bus_pkg::ibus_req_t       ibus_req,
    input  wire bus_pkg::ibus_resp_t ibus_resp,
    input  wire pipe_pkg::redirect_t redirect,
    output pipe_pkg::fetch_pair_t    pair,
    output logic                     pair_valid,
    input  wire logic                pair_ready
);

    pipe_pkg::fetch1_t     f1_next;
    pipe_pkg::fetch1_t     f1_q;
    pipe_pkg::fetch_pair_t pair_d;
    logic                  advance;
    logic                  busy;
    logic                  data_valid;
    logic [63:0]           data;
    logic                  pair_ok;
    logic                  take;
    logic                  stall;
    logic                  f1_free;

    assign pair_valid = pair.slot[0].valid;

    // output pair held while downstream is not ready
    assign stall = pair_valid && !pair_ready;

    // in-flight stage empty, or its result moves to out_reg now
    assign f1_free = !f1_q.valid || (pair_ok && !stall);

    // misaligned pc needs no bus, so it ignores busy
    assign advance = f1_free && (f1_next.bad_addr || !busy);

    assign take = f1_q.valid && !f1_q.bad_addr && pair_ok && !stall;

    pc_select pc_select_i (
        .clk      (clk),
        .reset    (reset),
        .redirect (redirect),
        .advance  (advance),
        .f1_next  (f1_next)
    );

    // emptied when its fetch completes with nothing new behind it
    pipe_reg #(.T(pipe_pkg::fetch1_t)) f1_reg (
        .clk   (clk),
        .reset (reset),
        .en    (advance),
        .flush (redirect.valid || (f1_free && !advance)),
        .d     (f1_next),
        .q     (f1_q)
    );

    ibus_master ibus_master_i (
        .clk        (clk),
        .reset      (reset),
        .start      (advance && !f1_next.bad_addr),
        .adr_in     (f1_next.pc),
        .busy       (busy),
        .ibus_req   (ibus_req),
        .ibus_resp  (ibus_resp),
        .drop       (redirect.valid),
        .data_valid (data_valid),
        .data       (data),
        .take       (take)
    );

    fetch_align fetch_align_i (
        .f1         (f1_q),
        .data_valid (data_valid),
        .data       (data),
        .pair       (pair_d),
        .pair_ok    (pair_ok)
    );

    pipe_reg #(.T(pipe_pkg::fetch_pair_t)) out_reg (
        .clk   (clk),
        .reset (reset),
        .en    (!stall),
        .flush (redirect.valid),
        .d     (pair_d),
        .q     (pair)
    );

endmodule

`default_nettype wire

// ==== testbench/wb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire bus_pkg::ibus_req_t  ibus_req,
    output bus_pkg::ibus_resp_t      ibus_resp
);

    logic [1:0] wait_n;
    logic [1:0] wait_cnt;

    // every word is predictable from its byte address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    // classic handshake, ack straight from stb once the wait states are spent
    always_comb begin
        ibus_resp.ack = ibus_req.cyc && ibus_req.stb && (wait_cnt == wait_n);
        ibus_resp.dat = {word_at(ibus_req.adr + 32'd4), word_at(ibus_req.adr)};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= 2'd0;
            wait_n   <= 2'd0;
        end else if (ibus_req.cyc && ibus_req.stb) begin
            if (ibus_resp.ack) begin
                wait_cnt <= 2'd0;
                // 0 to 3 wait states for the next cycle
                wait_n   <= 2'($urandom % 4);
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_frontend;

    // about 40 fetches per test, up to 5 cycles each, 5 tests, margin of 4
    localparam int TIMEOUT_CYCLES = 40 * 5 * 5 * 4;
    localparam int PAIR_W = $bits(pipe_pkg::fetch_pair_t);

    logic                  clk;
    logic                  reset;
    logic                  pair_ready;
    logic                  pair_valid;
    logic                  random_ready;
    logic                  in_cycle;
    logic                  hold_check;
    int                    cycle_cnt;
    int                    bus_starts;
    int                    n_checks;
    int                    n_errors;
    int                    n_tests;
    int unsigned           seed;
    bus_pkg::ibus_req_t    ibus_req;
    bus_pkg::ibus_resp_t   ibus_resp;
    pipe_pkg::redirect_t   redirect;
    pipe_pkg::fetch_pair_t pair;
    pipe_pkg::fetch_pair_t held_pair;
    pipe_pkg::fetch_pair_t got_q[$];

    fetch_frontend dut_i (
        .clk        (clk),
        .reset      (reset),
        .ibus_req   (ibus_req),
        .ibus_resp  (ibus_resp),
        .redirect   (redirect),
        .pair       (pair),
        .pair_valid (pair_valid),
        .pair_ready (pair_ready)
    );

    wb_mem_model mem_i (
        .clk       (clk),
        .reset     (reset),
        .ibus_req  (ibus_req),
        .ibus_resp (ibus_resp)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // downstream ready, random when back-pressure is on
    always @(posedge clk) begin
        #1;
        pair_ready = random_ready ? ($urandom % 2 == 0) : 1'b1;
    end

    task automatic report_mismatch(input string name, input logic [PAIR_W-1:0] exp,
                                   input logic [PAIR_W-1:0] act);
        n_errors++;
        $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, exp, act);
    endtask

    // bus cycle starts, held pair stability, transferred pairs
    always @(posedge clk) begin
        if (reset) begin
            in_cycle   = 1'b0;
            hold_check = 1'b0;
        end else begin
            if (ibus_req.cyc && ibus_req.stb && !in_cycle) begin
                bus_starts++;
                if (ibus_req.we || ibus_req.adr[2:0] != 3'b000) begin
                    n_errors++;
                    $display("error at %0t: bus cycle is a write or not doubleword aligned",
                             $time);
                end
            end
            in_cycle = ibus_req.cyc && ibus_req.stb && !ibus_resp.ack;
            if (hold_check) begin
                n_checks++;
                if (pair_valid !== 1'b1) report_mismatch("pair_valid", 1, pair_valid);
                if (pair !== held_pair) report_mismatch("pair", held_pair, pair);
            end
            hold_check = pair_valid && !pair_ready && !redirect.valid;
            held_pair  = pair;
            // a pair meeting a redirect is flushed, not delivered
            if (pair_valid && pair_ready && !redirect.valid) begin
                got_q.push_back(pair);
            end
        end
    end

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] next_pc(input logic [31:0] p);
        return p[2] ? p + 32'd4 : p + 32'd8;
    endfunction

    // expected pair for a fetch at pc p
    function automatic pipe_pkg::fetch_pair_t model_pair(input logic [31:0] p);
        pipe_pkg::fetch_pair_t e;
        logic                  bad;
        bad = (p[1:0] != 2'b00);
        e = '0;
        e.slot[0].valid     = 1'b1;
        e.slot[0].pc        = p;
        e.slot[0].exc       = bad;
        e.slot[0].raw_instr = bad ? 32'h0 : mem_word(p);
        if (!bad && !p[2]) begin
            e.slot[1].valid     = 1'b1;
            e.slot[1].pc        = p + 32'd4;
            e.slot[1].raw_instr = mem_word(p + 32'd4);
        end
        return e;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_pair(input pipe_pkg::fetch_pair_t exp,
                                input pipe_pkg::fetch_pair_t act, input int idx);
        string tag;
        for (int s = 0; s < 2; s++) begin
            tag = $sformatf("pair#%0d.slot[%0d]", idx, s);
            n_checks++;
            if (act.slot[s].valid !== exp.slot[s].valid) begin
                report_mismatch({tag, ".valid"}, exp.slot[s].valid, act.slot[s].valid);
            end
            if (exp.slot[s].valid) begin
                if (act.slot[s].pc !== exp.slot[s].pc) begin
                    report_mismatch({tag, ".pc"}, exp.slot[s].pc, act.slot[s].pc);
                end
                if (act.slot[s].raw_instr !== exp.slot[s].raw_instr) begin
                    report_mismatch({tag, ".raw_instr"}, exp.slot[s].raw_instr,
                                    act.slot[s].raw_instr);
                end
                if (act.slot[s].exc !== exp.slot[s].exc) begin
                    report_mismatch({tag, ".exc"}, exp.slot[s].exc, act.slot[s].exc);
                end
            end
        end
    endtask

    // first n transferred pairs must follow the pc stream from start_pc
    task automatic expect_stream(input logic [31:0] start_pc, input int n);
        logic [31:0]           p;
        pipe_pkg::fetch_pair_t got;
        p = start_pc;
        while (got_q.size() < n) wait_cycle();
        for (int i = 0; i < n; i++) begin
            got = got_q.pop_front();
            compare_pair(model_pair(p), got, i);
            p = next_pc(p);
        end
    endtask

    task automatic send_redirect(input logic is_exc, input logic [31:0] target);
        redirect.valid  = 1'b1;
        redirect.is_exc = is_exc;
        redirect.target = target;
        got_q.delete();
        wait_cycle();
        redirect = '0;
    endtask

    task automatic close_test(input string name, input int errs_before);
        n_tests++;
        if (n_errors == errs_before) begin
            $display("[pass] %s", name);
        end else begin
            $display("[fail] %s with %0d errors", name, n_errors - errs_before);
        end
    endtask

    task automatic check_reset_stream();
        int errs;
        errs = n_errors;
        repeat (5) wait_cycle();
        n_checks++;
        if (ibus_req.cyc !== 1'b0) report_mismatch("ibus_req.cyc", 0, ibus_req.cyc);
        if (ibus_req.stb !== 1'b0) report_mismatch("ibus_req.stb", 0, ibus_req.stb);
        if (pair_valid !== 1'b0) report_mismatch("pair_valid", 0, pair_valid);
        reset = 1'b0;
        got_q.delete();
        expect_stream(`FETCH_RESET_PC, 12);
        close_test("reset_stream", errs);
    endtask

    // bit 2 set, one slot from the upper word, then aligned again
    task automatic branch_to_upper_word();
        int errs;
        errs = n_errors;
        send_redirect(1'b0, 32'hbfc0_1234);
        expect_stream(32'hbfc0_1234, 6);
        close_test("branch_to_upper_word", errs);
    endtask

    task automatic misaligned_redirect();
        int errs;
        int starts;
        errs = n_errors;
        send_redirect(1'b0, 32'hbfc0_2002);
        starts = bus_starts;
        expect_stream(32'hbfc0_2002, 4);
        n_checks++;
        if (bus_starts != starts) report_mismatch("bus cycle starts", starts, bus_starts);
        close_test("misaligned_redirect", errs);
    endtask

    task automatic random_back_pressure();
        int errs;
        errs = n_errors;
        send_redirect(1'b0, 32'hbfc0_4004);
        random_ready = 1'b1;
        expect_stream(32'hbfc0_4004, 30);
        random_ready = 1'b0;
        close_test("random_back_pressure", errs);
    endtask

    // redirect while stb is up and no ack yet
    task automatic redirect_during_bus_cycle();
        int errs;
        errs = n_errors;
        while (!(ibus_req.cyc && !ibus_resp.ack)) wait_cycle();
        send_redirect(1'b0, 32'hbfc0_6000);
        expect_stream(32'hbfc0_6000, 5);
        while (!(ibus_req.cyc && !ibus_resp.ack)) wait_cycle();
        send_redirect(1'b1, 32'h0000_1238);
        expect_stream(`FETCH_EXC_ENTRY, 5);
        close_test("redirect_during_bus_cycle", errs);
    endtask

    initial begin
        seed = 32'hfc3fe18d;
        void'($urandom(seed));
        clk          = 1'b0;
        reset        = 1'b1;
        redirect     = '0;
        pair_ready   = 1'b1;
        random_ready = 1'b0;
        in_cycle     = 1'b0;
        hold_check   = 1'b0;
        held_pair    = '0;
        cycle_cnt    = 0;
        bus_starts   = 0;
        n_checks     = 0;
        n_errors     = 0;
        n_tests      = 0;

        check_reset_stream();
        branch_to_upper_word();
        misaligned_redirect();
        random_back_pressure();
        redirect_during_bus_cycle();

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dual_fetch.f ====
+incdir+source
source/bus_pkg.sv
source/pipe_pkg.sv
source/pipe_reg.sv
source/pc_select.sv
source/ibus_master.sv
source/fetch_align.sv
source/fetch_frontend.sv
testbench/wb_mem_model.sv
testbench/tb_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: dual_fetch

sources:
  - include_dirs:
      - source
    files:
      - source/bus_pkg.sv
      - source/pipe_pkg.sv
      - source/pipe_reg.sv
      - source/pc_select.sv
      - source/ibus_master.sv
      - source/fetch_align.sv
      - source/fetch_frontend.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/wb_mem_model.sv
      - testbench/tb_fetch_frontend.sv
